//--- hdl/psram_pkg.sv
`default_nettype none

package psram_pkg;

    localparam int data_width = 16;
    localparam int addr_width = 23;
    localparam int burst_len  = 4;
    localparam int latency    = 4;   // Cycles from command to first data
    localparam int mem_words  = 1024;

    localparam int mem_aw     = $clog2(mem_words);
    localparam int beat_width = $clog2(burst_len);
    localparam int wait_width = $clog2(latency);

    // Latency code 3 gives four cycles, burst code 1 gives four words
    localparam logic [2:0] lat_code_val   = 3'b011;
    localparam logic [2:0] burst_len_code = 3'b001;

    // Bus configuration register layout, msb first
    typedef struct packed {
        logic [2:0] reserved_hi;   // Must be zero
        logic [1:0] reg_sel;       // 2'b10 selects the BCR
        logic [1:0] reserved_mid;
        logic       op_mode;       // 0 is synchronous burst
        logic       lat_type;      // 1 is fixed latency
        logic [2:0] lat_code;
        logic       wait_pol;      // 1 is active high
        logic       reserved_9;
        logic       wait_cfg;      // 1 asserts one cycle before data
        logic [1:0] reserved_lo;
        logic [1:0] drive;
        logic       burst_wrap;    // 1 is no wrap
        logic [2:0] burst_length;
    } bcr_cfg_t;

    // Address pins carry the BCR value while cre is high
    typedef union packed {
        bcr_cfg_t                cfg;
        logic [addr_width-1:0]   word;
    } psram_addr_u;

    localparam bcr_cfg_t bcr_value = '{
        reserved_hi:  3'b000,
        reg_sel:      2'b10,
        reserved_mid: 2'b00,
        op_mode:      1'b0,
        lat_type:     1'b1,
        lat_code:     lat_code_val,
        wait_pol:     1'b1,
        reserved_9:   1'b0,
        wait_cfg:     1'b1,
        reserved_lo:  2'b00,
        drive:        2'b01,
        burst_wrap:   1'b1,
        burst_length: burst_len_code
    };

    // Word 0 sits at the start address
    typedef struct packed {
        logic [data_width-1:0] w3;
        logic [data_width-1:0] w2;
        logic [data_width-1:0] w1;
        logic [data_width-1:0] w0;
    } burst_t;

    typedef struct packed {
        psram_addr_u           addr;
        logic                  adv_n;
        logic                  ce_n;
        logic                  oe_n;
        logic                  we_n;
        logic                  cre;
        logic [data_width-1:0] wdata;
    } psram_cmd_t;

    typedef struct packed {
        logic [data_width-1:0] rdata;
        logic                  mem_wait;
    } psram_rsp_t;

endpackage

`default_nettype wire

//--- hdl/psram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module psram_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic                           we,
    input  logic [psram_pkg::addr_width-1:0] addr,
    input  psram_pkg::burst_t              wdata,
    output logic                           ready,
    output logic                           done,
    output psram_pkg::burst_t              rdata,
    output psram_pkg::psram_cmd_t          cmd,
    input  psram_pkg::psram_rsp_t          rsp
);
    import psram_pkg::*;

    typedef enum logic [2:0] {
        st_cfg,
        st_idle,
        st_cmd,
        st_wait,
        st_data
    } ctrl_state_t;

    ctrl_state_t state, next_state;

    logic                                  cfg_pend;   // BCR not yet written
    logic                                  accept;
    logic                                  last_beat;
    logic [beat_width-1:0]                 beat;
    logic [addr_width-1:0]                 addr_q;
    logic                                  wr_q;
    logic [burst_len-1:0][data_width-1:0]  wr_words;
    logic [burst_len-1:0][data_width-1:0]  rd_buf;
    logic [burst_len-1:0][data_width-1:0]  rd_next;

    assign accept    = (state == st_idle) && req && ready;
    assign last_beat = (beat == beat_width'(burst_len - 1));

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (cfg_pend)
                    next_state = st_cfg;
                else if (accept)
                    next_state = st_cmd;
            end
            st_cfg:  next_state = st_idle;
            st_cmd:  next_state = st_wait;
            st_wait: begin
                // Device drops wait one cycle ahead of the first word
                if (!rsp.mem_wait)
                    next_state = st_data;
            end
            st_data: begin
                if (last_beat)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            cfg_pend <= 1'b1;
            ready    <= 1'b0;
            done     <= 1'b0;
            beat     <= '0;
        end else begin
            state <= next_state;
            if (state == st_cfg)
                cfg_pend <= 1'b0;
            ready <= (state == st_idle) && !cfg_pend && !accept;
            done  <= (state == st_data) && last_beat;
            if (state == st_data)
                beat <= beat + 1'b1;
            else
                beat <= '0;
        end
    end

    // Read word of this beat merged into the collected burst
    always_comb begin
        rd_next       = rd_buf;
        rd_next[beat] = rsp.rdata;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= addr;
            wr_q     <= we;
            wr_words <= wdata;
        end
        if (state == st_data && !wr_q) begin
            rd_buf <= rd_next;
            if (last_beat)
                rdata <= rd_next;   // Held until the next read completes
        end
    end

    always_comb begin
        cmd.addr.word = addr_q;
        cmd.adv_n     = 1'b1;
        cmd.ce_n      = 1'b1;
        cmd.oe_n      = 1'b1;
        cmd.we_n      = 1'b1;
        cmd.cre       = 1'b0;
        cmd.wdata     = wr_words[beat];
        case (state)
            st_cfg: begin
                cmd.addr.cfg = bcr_value;
                cmd.adv_n    = 1'b0;
                cmd.ce_n     = 1'b0;
                cmd.cre      = 1'b1;
            end
            st_cmd: begin
                cmd.adv_n = 1'b0;
                cmd.ce_n  = 1'b0;
                cmd.we_n  = !wr_q;
            end
            st_wait: begin
                cmd.ce_n = 1'b0;
                cmd.we_n = !wr_q;
            end
            st_data: begin
                cmd.ce_n = 1'b0;
                cmd.oe_n = wr_q;    // Output enable only for reads
                cmd.we_n = !wr_q;
            end
            default: ;
        endcase
    end

    a_req_when_ready: assert property (@(posedge clk) disable iff (rst)
        req |-> ready)
        else $error("psram_ctrl: req while not ready");

    // Device must be quiet whenever the controller sits idle
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle) |-> (cmd.ce_n && !rsp.mem_wait))
        else $error("psram_ctrl: chip selected or wait high in idle");

endmodule

`default_nettype wire

//--- hdl/psram_model.sv
`timescale 1ns/1ps
`default_nettype none

module psram_model (
    input  logic                  clk,
    input  logic                  rst,
    input  psram_pkg::psram_cmd_t cmd,
    output psram_pkg::psram_rsp_t rsp
);
    import psram_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_data
    } model_state_t;

    model_state_t state, next_state;

    logic [addr_width-1:0] cur_addr;
    logic [wait_width-1:0] wait_cnt;
    logic                  mem_wait_q;
    logic                  is_write;
    bcr_cfg_t              cfg_q;
    logic                  cfg_valid;
    logic [addr_width-1:0] cfg_bits;
    logic                  cmd_valid;
    logic                  mem_cmd;
    logic                  cfg_cmd;

    logic [data_width-1:0] mem [mem_words];

    initial begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    // Command is sampled with chip enable and address valid both low
    assign cmd_valid = !cmd.ce_n && !cmd.adv_n;
    assign mem_cmd   = cmd_valid && !cmd.cre;
    assign cfg_cmd   = cmd_valid && cmd.cre;
    assign cfg_bits  = cfg_q;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (mem_cmd)
                    next_state = st_wait;
            end
            st_wait: begin
                if (wait_cnt == wait_width'(latency - 2))   // First word next cycle
                    next_state = st_data;
            end
            st_data: begin
                if (cmd.ce_n)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            wait_cnt   <= '0;
            mem_wait_q <= 1'b0;
            cfg_q      <= '0;
            cfg_valid  <= 1'b0;
        end else begin
            state <= next_state;

            if (state == st_idle)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;

            case (state)
                st_idle: mem_wait_q <= mem_cmd;
                // Released one cycle before the first data beat
                st_wait: mem_wait_q <= (wait_cnt < wait_width'(latency - 3));
                default: mem_wait_q <= 1'b0;
            endcase

            if (state == st_idle && cfg_cmd) begin
                cfg_q     <= cmd.addr.cfg;
                cfg_valid <= 1'b1;
            end
        end
    end

    // Address loads while idle and counts through the burst
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            cur_addr <= cmd.addr.word;
            is_write <= !cmd.we_n;
        end else if (state == st_data) begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && !cmd.ce_n && is_write)
            mem[cur_addr[mem_aw-1:0]] <= cmd.wdata;
    end

    // Idle readback returns the stored configuration word
    assign rsp.rdata    = (state == st_idle) ? cfg_bits[data_width-1:0]
                                             : mem[cur_addr[mem_aw-1:0]];
    assign rsp.mem_wait = mem_wait_q;

    // Every memory access must run with the configuration the package assumes
    a_cfg_match: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle && mem_cmd) |->
            (cfg_valid && cfg_q.lat_code == lat_code_val
             && cfg_q.burst_length == burst_len_code))
        else $error("psram_model: access without matching BCR");

    a_oe_we_excl: assert property (@(posedge clk) disable iff (rst)
        !(!cmd.oe_n && !cmd.we_n))
        else $error("psram_model: oe_n and we_n both low");

endmodule

`default_nettype wire

//--- hdl/psram_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module psram_subsys (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req,
    input  logic                             we,
    input  logic [psram_pkg::addr_width-1:0] addr,
    input  psram_pkg::burst_t                wdata,
    output logic                             ready,
    output logic                             done,
    output psram_pkg::burst_t                rdata
);
    import psram_pkg::*;

    psram_cmd_t cmd;
    psram_rsp_t dev_rsp;    // As driven by the device
    psram_rsp_t ctrl_rsp;   // As seen by the controller

    // Read half of the shared data pins, valid only under output enable
    always_comb begin
        ctrl_rsp.mem_wait = dev_rsp.mem_wait;
        ctrl_rsp.rdata    = cmd.oe_n ? '0 : dev_rsp.rdata;
    end

    psram_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .done  (done),
        .rdata (rdata),
        .cmd   (cmd),
        .rsp   (ctrl_rsp)
    );

    psram_model u_model (
        .clk (clk),
        .rst (rst),
        .cmd (cmd),
        .rsp (dev_rsp)
    );

endmodule

`default_nettype wire

//--- tests/tb_psram_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_psram_subsys;
    import psram_pkg::*;

    localparam int timeout_cycles = 100;
    localparam int random_ops     = 40;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic                  we;
    logic [addr_width-1:0] addr;
    burst_t                wdata;
    logic                  ready;
    logic                  done;
    burst_t                rdata;

    logic [data_width-1:0] shadow [mem_words];   // Mirror of completed writes
    burst_t                exp_rdata;
    logic                  chk_read;              // Current burst is a read
    int                    in_flight;
    int                    req_count;
    int                    done_count;

    psram_subsys i_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .done  (done),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Bookkeeping of accepted requests against done pulses
    always @(posedge clk) begin
        if (rst) begin
            in_flight  <= 0;
            req_count  <= 0;
            done_count <= 0;
        end else begin
            if (req && !done)
                in_flight <= in_flight + 1;
            else if (done && !req)
                in_flight <= in_flight - 1;
            if (req)
                req_count <= req_count + 1;
            if (done)
                done_count <= done_count + 1;
        end
    end

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first failure");
    endtask

    a_reset_quiet: assert property (@(posedge clk) rst |=> (!ready && !done))
        else begin
            $display("error %0t: ready or done high during reset", $time);
            stop_on_failure();
        end

    a_ready_falls: assert property (@(posedge clk) disable iff (rst) req |=> !ready)
        else begin
            $display("error %0t: ready still high the cycle after req", $time);
            stop_on_failure();
        end

    a_busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        (in_flight != 0) |-> !ready)
        else begin
            $display("error %0t: ready high while a burst is in flight", $time);
            stop_on_failure();
        end

    a_single_done: assert property (@(posedge clk) disable iff (rst)
        done |-> (in_flight == 1))
        else begin
            $display("error %0t: done without exactly one burst in flight", $time);
            stop_on_failure();
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $display("error %0t: done longer than one cycle", $time);
            stop_on_failure();
        end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (done && chk_read) |-> (rdata == exp_rdata))
        else begin
            $display("error %0t: read got %h expected %h", $time, rdata, exp_rdata);
            stop_on_failure();
        end

    function automatic burst_t shadow_burst(input logic [addr_width-1:0] a);
        burst_t b;
        for (int i = 0; i < burst_len; i++)
            b[i*data_width +: data_width] = shadow[mem_aw'(a + addr_width'(i))];
        return b;
    endfunction

    function automatic burst_t random_burst();
        burst_t b;
        b.w0 = data_width'($urandom);
        b.w1 = data_width'($urandom);
        b.w2 = data_width'($urandom);
        b.w3 = data_width'($urandom);
        return b;
    endfunction

    task automatic check_rdata(input burst_t expected, input string what);
        assert (rdata == expected)
        else begin
            $display("error %0t: %s got %h expected %h", $time, what, rdata, expected);
            stop_on_failure();
        end
    endtask

    // Entered right after a rising edge, like every wait below
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timed out waiting for ready after %0d cycles", cycles);
                stop_on_failure();
            end
        end
    endtask

    task automatic run_burst(input logic is_wr, input logic [addr_width-1:0] a,
                             input burst_t data);
        int cycles;
        wait_ready();
        req       <= 1'b1;
        we        <= is_wr;
        addr      <= a;
        wdata     <= data;
        chk_read  <= !is_wr;
        exp_rdata <= shadow_burst(a);   // Expected words for a read
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timed out waiting for done of burst at address %h", a);
                stop_on_failure();
            end
        end
        if (is_wr) begin
            for (int i = 0; i < burst_len; i++)
                shadow[mem_aw'(a + addr_width'(i))] = data[i*data_width +: data_width];
        end
    endtask

    initial begin
        burst_t                b1;
        burst_t                b2;
        logic [addr_width-1:0] a;
        logic                  wr;
        int                    seed_ret;

        seed_ret  = $urandom(32'h9a580503);
        rst       = 1'b1;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        exp_rdata = '0;
        chk_read  = 1'b0;
        for (int i = 0; i < mem_words; i++)
            shadow[i] = '0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        wait_ready();   // Configuration write has finished

        run_burst(1'b0, 23'h300, '0);   // Never written
        check_rdata('0, "unwritten read");

        b1 = random_burst();
        run_burst(1'b1, 23'h040, b1);
        run_burst(1'b0, 23'h040, '0);
        check_rdata(b1, "write then read");

        // Second burst overwrites the upper half of the first
        b1 = random_burst();
        b2 = random_burst();
        run_burst(1'b1, 23'h080, b1);
        run_burst(1'b1, 23'h082, b2);
        run_burst(1'b0, 23'h080, '0);
        check_rdata({b2.w1, b2.w0, b1.w1, b1.w0}, "overlapping bursts");

        for (int n = 0; n < random_ops; n++) begin
            wr = 1'($urandom % 2);
            a  = 23'h200 + addr_width'($urandom % 12);
            b1 = random_burst();
            run_burst(wr, a, b1);
        end

        @(posedge clk);
        if (req_count == done_count && in_flight == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("error %0t: %0d requests but %0d done pulses", $time,
                     req_count, done_count);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

//--- src.f
hdl/psram_pkg.sv
hdl/psram_ctrl.sv
hdl/psram_model.sv
hdl/psram_subsys.sv
tests/tb_psram_subsys.sv

//--- run.sh
#!/bin/sh
# Build the psram testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_psram_subsys \
    -o sim_psram

# Result is taken from the log
./obj_dir/sim_psram > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "psram simulation passed"
else
    echo "psram simulation did not pass"
    exit 1
fi
